// File: design/rvc_pkg.sv
// Shared types, field positions and encodings for the RVC expander
// Imported by every expander module and by the testbench
package rvc_pkg;

    typedef logic [15:0] instr16_t;
    typedef logic [31:0] instr32_t;
    typedef logic [4:0]  reg_addr_t;

    typedef struct packed {
        instr32_t instr;   // Expanded base instruction
        logic     illegal; // Reserved or unsupported encoding
    } rvc_result_t;

    // ------------------------------------------------------------
    // Compressed instruction layout
    localparam int ci_opcode_lsb_c = 0;
    localparam int ci_opcode_msb_c = 1;
    localparam int ci_funct3_lsb_c = 13;
    localparam int ci_funct3_msb_c = 15;
    localparam int ci_rd_3_lsb_c   = 2;
    localparam int ci_rd_3_msb_c   = 4;
    localparam int ci_rs1_3_lsb_c  = 7;
    localparam int ci_rs1_3_msb_c  = 9;
    localparam int ci_rs2_3_lsb_c  = 2;
    localparam int ci_rs2_3_msb_c  = 4;
    localparam int ci_rd_5_lsb_c   = 7;
    localparam int ci_rd_5_msb_c   = 11;
    localparam int ci_rs1_5_lsb_c  = 7;
    localparam int ci_rs1_5_msb_c  = 11;
    localparam int ci_rs2_5_lsb_c  = 2;
    localparam int ci_rs2_5_msb_c  = 6;

    // ------------------------------------------------------------
    // Base instruction layout
    localparam int instr_opcode_lsb_c  = 0;
    localparam int instr_opcode_msb_c  = 6;
    localparam int instr_rd_lsb_c      = 7;
    localparam int instr_rd_msb_c      = 11;
    localparam int instr_funct3_lsb_c  = 12;
    localparam int instr_funct3_msb_c  = 14;
    localparam int instr_rs1_lsb_c     = 15;
    localparam int instr_rs1_msb_c     = 19;
    localparam int instr_rs2_lsb_c     = 20;
    localparam int instr_rs2_msb_c     = 24;
    localparam int instr_funct7_lsb_c  = 25;
    localparam int instr_funct7_msb_c  = 31;
    localparam int instr_imm12_lsb_c   = 20;
    localparam int instr_imm12_msb_c   = 31;
    localparam int instr_imm20_lsb_c   = 12;
    localparam int instr_imm20_msb_c   = 31;
    localparam int instr_funct12_lsb_c = 20;
    localparam int instr_funct12_msb_c = 31;

    // Major opcodes
    localparam logic [6:0] opcode_load_c   = 7'b0000011;
    localparam logic [6:0] opcode_store_c  = 7'b0100011;
    localparam logic [6:0] opcode_alui_c   = 7'b0010011;
    localparam logic [6:0] opcode_alu_c    = 7'b0110011;
    localparam logic [6:0] opcode_lui_c    = 7'b0110111;
    localparam logic [6:0] opcode_jal_c    = 7'b1101111;
    localparam logic [6:0] opcode_jalr_c   = 7'b1100111;
    localparam logic [6:0] opcode_branch_c = 7'b1100011;
    localparam logic [6:0] opcode_system_c = 7'b1110011;

    // Minor opcodes
    localparam logic [2:0] funct3_lw_c     = 3'b010;
    localparam logic [2:0] funct3_sw_c     = 3'b010;
    localparam logic [2:0] funct3_subadd_c = 3'b000;
    localparam logic [2:0] funct3_sll_c    = 3'b001;
    localparam logic [2:0] funct3_sr_c     = 3'b101;
    localparam logic [2:0] funct3_xor_c    = 3'b100;
    localparam logic [2:0] funct3_or_c     = 3'b110;
    localparam logic [2:0] funct3_and_c    = 3'b111;
    localparam logic [2:0] funct3_beq_c    = 3'b000;
    localparam logic [2:0] funct3_bne_c    = 3'b001;

    localparam logic [6:0]  funct7_base_c    = 7'b0000000;
    localparam logic [6:0]  funct7_alt_c     = 7'b0100000; // SUB and SRAI
    localparam logic [11:0] funct12_ebreak_c = 12'h001;

    // Fixed registers
    localparam reg_addr_t reg_zero_c = 5'd0;
    localparam reg_addr_t reg_ra_c   = 5'd1; // Link register
    localparam reg_addr_t reg_sp_c   = 5'd2; // Stack pointer

    // Three-bit register field maps onto x8 - x15
    function automatic reg_addr_t prime_reg(input logic [2:0] field);
        return {2'b01, field};
    endfunction

endpackage

// File: design/rvc_quadrant0_decoder.sv
// Quadrant 0 expander: C.ADDI4SPN, C.LW and C.SW
// Purely combinational, selected by the top level on opcode 00
module rvc_quadrant0_decoder
    import rvc_pkg::*;
(
    input  instr16_t    ci_instr16_i,
    output rvc_result_t result_o
);

    logic [2:0] funct3;
    reg_addr_t  base_p;  // Prime base register
    reg_addr_t  low_p;   // Prime rd (load) or rs2 (store)
    instr32_t   w;
    logic       ill;

    assign funct3 = ci_instr16_i[ci_funct3_msb_c:ci_funct3_lsb_c];
    assign base_p = prime_reg(ci_instr16_i[ci_rs1_3_msb_c:ci_rs1_3_lsb_c]);
    assign low_p  = prime_reg(ci_instr16_i[ci_rs2_3_msb_c:ci_rs2_3_lsb_c]);

    always_comb begin
        w   = '0;
        ill = 1'b0;
        case (funct3)
            3'b010, 3'b011: begin // C.LW, float load form
                w[instr_opcode_msb_c:instr_opcode_lsb_c] = opcode_load_c;
                w[instr_funct3_msb_c:instr_funct3_lsb_c] = funct3_lw_c;
                w[instr_rs1_msb_c:instr_rs1_lsb_c]       = base_p;
                w[instr_rd_msb_c:instr_rd_lsb_c]         =
                    prime_reg(ci_instr16_i[ci_rd_3_msb_c:ci_rd_3_lsb_c]);
                w[instr_imm12_msb_c:instr_imm12_lsb_c]   =
                    {5'b0, ci_instr16_i[5], ci_instr16_i[12:10], ci_instr16_i[6], 2'b00};
                ill = funct3[0]; // C.FLW
            end
            3'b110, 3'b111: begin // C.SW, float store form
                w[instr_opcode_msb_c:instr_opcode_lsb_c] = opcode_store_c;
                w[instr_funct3_msb_c:instr_funct3_lsb_c] = funct3_sw_c;
                w[instr_rs1_msb_c:instr_rs1_lsb_c]       = base_p;
                w[instr_rs2_msb_c:instr_rs2_lsb_c]       = low_p;
                w[instr_funct7_msb_c:instr_funct7_lsb_c] = {5'b0, ci_instr16_i[5], ci_instr16_i[12]};
                w[instr_rd_msb_c:instr_rd_lsb_c]         =
                    {ci_instr16_i[11:10], ci_instr16_i[6], 2'b00};
                ill = funct3[0]; // C.FSW
            end
            default: begin
                // C.ADDI4SPN, scaled unsigned offset added to sp
                w[instr_opcode_msb_c:instr_opcode_lsb_c] = opcode_alui_c;
                w[instr_funct3_msb_c:instr_funct3_lsb_c] = funct3_subadd_c;
                w[instr_rs1_msb_c:instr_rs1_lsb_c]       = reg_sp_c;
                w[instr_rd_msb_c:instr_rd_lsb_c]         = low_p;
                w[instr_imm12_msb_c:instr_imm12_lsb_c]   = {2'b00, ci_instr16_i[10:7],
                    ci_instr16_i[12:11], ci_instr16_i[5], ci_instr16_i[6], 2'b00};
                // All-zero word, zero offset and the reserved slots
                ill = (ci_instr16_i[12:5] == 8'h00) || (funct3 != 3'b000);
            end
        endcase
    end

    assign result_o = '{instr: w, illegal: ill};

endmodule

// File: design/rvc_quadrant1_decoder.sv
// Quadrant 1 expander: constants, immediate and register ALU ops, jumps, branches
// Purely combinational, selected by the top level on opcode 01
module rvc_quadrant1_decoder
    import rvc_pkg::*;
(
    input  instr16_t    ci_instr16_i,
    output rvc_result_t result_o
);

    logic [2:0]  funct3;
    logic [20:0] imm_j;  // C.J / C.JAL offset
    logic [12:0] imm_b;  // C.BEQZ / C.BNEZ offset
    logic [11:0] imm_i;  // Six-bit signed immediate
    reg_addr_t   rd_5;
    reg_addr_t   rs1_p;
    instr32_t    w;
    logic        ill;

    assign funct3 = ci_instr16_i[ci_funct3_msb_c:ci_funct3_lsb_c];
    assign rd_5   = ci_instr16_i[ci_rd_5_msb_c:ci_rd_5_lsb_c];
    assign rs1_p  = prime_reg(ci_instr16_i[ci_rs1_3_msb_c:ci_rs1_3_lsb_c]);
    assign imm_i  = {{7{ci_instr16_i[12]}}, ci_instr16_i[6:2]};

    assign imm_j = {{10{ci_instr16_i[12]}}, ci_instr16_i[8], ci_instr16_i[10:9],
                    ci_instr16_i[6], ci_instr16_i[7], ci_instr16_i[2], ci_instr16_i[11],
                    ci_instr16_i[5:3], 1'b0};
    assign imm_b = {{5{ci_instr16_i[12]}}, ci_instr16_i[6:5], ci_instr16_i[2],
                    ci_instr16_i[11:10], ci_instr16_i[4:3], 1'b0};

    always_comb begin
        w   = '0;
        ill = 1'b0;
        case (funct3)
            3'b001, 3'b101: begin // C.JAL, C.J
                w[instr_opcode_msb_c:instr_opcode_lsb_c] = opcode_jal_c;
                w[instr_rd_msb_c:instr_rd_lsb_c]         = funct3[2] ? reg_zero_c : reg_ra_c;
                w[instr_imm20_msb_c:instr_imm20_lsb_c]   =
                    {imm_j[20], imm_j[10:1], imm_j[11], imm_j[19:12]};
            end
            3'b110, 3'b111: begin // C.BEQZ, C.BNEZ
                w[instr_opcode_msb_c:instr_opcode_lsb_c] = opcode_branch_c;
                w[instr_funct3_msb_c:instr_funct3_lsb_c] = funct3[0] ? funct3_bne_c : funct3_beq_c;
                w[instr_rs1_msb_c:instr_rs1_lsb_c]       = rs1_p;
                w[instr_rs2_msb_c:instr_rs2_lsb_c]       = reg_zero_c;
                w[instr_funct7_msb_c:instr_funct7_lsb_c] = {imm_b[12], imm_b[10:5]};
                w[instr_rd_msb_c:instr_rd_lsb_c]         = {imm_b[4:1], imm_b[11]};
            end
            3'b000, 3'b010: begin
                // C.ADDI and C.NOP add to rd, C.LI adds to x0
                w[instr_opcode_msb_c:instr_opcode_lsb_c] = opcode_alui_c;
                w[instr_funct3_msb_c:instr_funct3_lsb_c] = funct3_subadd_c;
                w[instr_rd_msb_c:instr_rd_lsb_c]         = rd_5;
                w[instr_rs1_msb_c:instr_rs1_lsb_c]       = funct3[1] ? reg_zero_c :
                    ci_instr16_i[ci_rs1_5_msb_c:ci_rs1_5_lsb_c];
                w[instr_imm12_msb_c:instr_imm12_lsb_c]   = imm_i;
            end
            3'b011: begin
                if (rd_5 == reg_sp_c) begin // C.ADDI16SP
                    w[instr_opcode_msb_c:instr_opcode_lsb_c] = opcode_alui_c;
                    w[instr_funct3_msb_c:instr_funct3_lsb_c] = funct3_subadd_c;
                    w[instr_rs1_msb_c:instr_rs1_lsb_c]       = reg_sp_c;
                    w[instr_rd_msb_c:instr_rd_lsb_c]         = reg_sp_c;
                    w[instr_imm12_msb_c:instr_imm12_lsb_c]   = {{3{ci_instr16_i[12]}},
                        ci_instr16_i[4:3], ci_instr16_i[5], ci_instr16_i[2], ci_instr16_i[6],
                        4'b0000};
                end else begin // C.LUI
                    w[instr_opcode_msb_c:instr_opcode_lsb_c] = opcode_lui_c;
                    w[instr_rd_msb_c:instr_rd_lsb_c]         = rd_5;
                    w[instr_imm20_msb_c:instr_imm20_lsb_c]   =
                        {{14{ci_instr16_i[12]}}, ci_instr16_i[12], ci_instr16_i[6:2]};
                end
                ill = ({ci_instr16_i[12], ci_instr16_i[6:2]} == 6'd0); // Zero immediate reserved
            end
            default: begin
                // ------------------------------------------------------------
                // Shifts, C.ANDI and register-register ops on x8 - x15
                w[instr_rd_msb_c:instr_rd_lsb_c]   = rs1_p;
                w[instr_rs1_msb_c:instr_rs1_lsb_c] = rs1_p;
                w[instr_rs2_msb_c:instr_rs2_lsb_c] =
                    prime_reg(ci_instr16_i[ci_rs2_3_msb_c:ci_rs2_3_lsb_c]);
                case (ci_instr16_i[11:10])
                    2'b00, 2'b01: begin // C.SRLI, C.SRAI
                        w[instr_opcode_msb_c:instr_opcode_lsb_c] = opcode_alui_c;
                        w[instr_funct3_msb_c:instr_funct3_lsb_c] = funct3_sr_c;
                        w[instr_funct7_msb_c:instr_funct7_lsb_c] =
                            ci_instr16_i[10] ? funct7_alt_c : funct7_base_c;
                        w[instr_rs2_msb_c:instr_rs2_lsb_c]       = ci_instr16_i[6:2]; // shamt
                        ill = ci_instr16_i[12]; // shamt[5] not on RV32
                    end
                    2'b10: begin // C.ANDI
                        w[instr_opcode_msb_c:instr_opcode_lsb_c] = opcode_alui_c;
                        w[instr_funct3_msb_c:instr_funct3_lsb_c] = funct3_and_c;
                        w[instr_imm12_msb_c:instr_imm12_lsb_c]   = imm_i;
                    end
                    default: begin
                        w[instr_opcode_msb_c:instr_opcode_lsb_c] = opcode_alu_c;
                        case (ci_instr16_i[6:5])
                            2'b00: begin // C.SUB
                                w[instr_funct3_msb_c:instr_funct3_lsb_c] = funct3_subadd_c;
                                w[instr_funct7_msb_c:instr_funct7_lsb_c] = funct7_alt_c;
                            end
                            2'b01:   w[instr_funct3_msb_c:instr_funct3_lsb_c] = funct3_xor_c;
                            2'b10:   w[instr_funct3_msb_c:instr_funct3_lsb_c] = funct3_or_c;
                            default: w[instr_funct3_msb_c:instr_funct3_lsb_c] = funct3_and_c;
                        endcase
                        ill = ci_instr16_i[12]; // RV64 word ops
                    end
                endcase
            end
        endcase
    end

    assign result_o = '{instr: w, illegal: ill};

endmodule

// File: design/rvc_quadrant2_decoder.sv
// Quadrant 2 expander: C.SLLI, stack loads and stores, moves, register jumps, C.EBREAK
// Also takes opcode 11, since full-size words never reach the expander
module rvc_quadrant2_decoder
    import rvc_pkg::*;
(
    input  instr16_t    ci_instr16_i,
    output rvc_result_t result_o
);

    logic [2:0] funct3;
    reg_addr_t  rd_5;
    reg_addr_t  rs2_5;
    instr32_t   w;
    logic       ill;

    assign funct3 = ci_instr16_i[ci_funct3_msb_c:ci_funct3_lsb_c];
    assign rd_5   = ci_instr16_i[ci_rs1_5_msb_c:ci_rs1_5_lsb_c]; // rd and rs1 share bits 11:7
    assign rs2_5  = ci_instr16_i[ci_rs2_5_msb_c:ci_rs2_5_lsb_c];

    always_comb begin
        w   = '0;
        ill = 1'b0;
        case (funct3)
            3'b000: begin // C.SLLI
                w[instr_opcode_msb_c:instr_opcode_lsb_c] = opcode_alui_c;
                w[instr_funct3_msb_c:instr_funct3_lsb_c] = funct3_sll_c;
                w[instr_funct7_msb_c:instr_funct7_lsb_c] = funct7_base_c;
                w[instr_rd_msb_c:instr_rd_lsb_c]         = rd_5;
                w[instr_rs1_msb_c:instr_rs1_lsb_c]       = rd_5;
                w[instr_rs2_msb_c:instr_rs2_lsb_c]       = ci_instr16_i[6:2]; // shamt
                ill = ci_instr16_i[12];
            end
            3'b010, 3'b011: begin // C.LWSP, float form
                w[instr_opcode_msb_c:instr_opcode_lsb_c] = opcode_load_c;
                w[instr_funct3_msb_c:instr_funct3_lsb_c] = funct3_lw_c;
                w[instr_rs1_msb_c:instr_rs1_lsb_c]       = reg_sp_c;
                w[instr_rd_msb_c:instr_rd_lsb_c]         = ci_instr16_i[ci_rd_5_msb_c:ci_rd_5_lsb_c];
                w[instr_imm12_msb_c:instr_imm12_lsb_c]   = {4'b0, ci_instr16_i[3:2],
                    ci_instr16_i[12], ci_instr16_i[6:4], 2'b00};
                ill = funct3[0]; // C.FLWSP
            end
            3'b110, 3'b111: begin // C.SWSP, float form
                w[instr_opcode_msb_c:instr_opcode_lsb_c] = opcode_store_c;
                w[instr_funct3_msb_c:instr_funct3_lsb_c] = funct3_sw_c;
                w[instr_rs1_msb_c:instr_rs1_lsb_c]       = reg_sp_c;
                w[instr_rs2_msb_c:instr_rs2_lsb_c]       = rs2_5;
                w[instr_funct7_msb_c:instr_funct7_lsb_c] = {4'b0, ci_instr16_i[8:7], ci_instr16_i[12]};
                w[instr_rd_msb_c:instr_rd_lsb_c]         = {ci_instr16_i[11:9], 2'b00};
                ill = funct3[0]; // C.FSWSP
            end
            default: begin
                // ------------------------------------------------------------
                // Bit 12 picks the link or add form, rs2 == x0 the jump forms
                if (rs2_5 == reg_zero_c) begin
                    if (ci_instr16_i[12] && (rd_5 == reg_zero_c)) begin // C.EBREAK
                        w[instr_opcode_msb_c:instr_opcode_lsb_c]   = opcode_system_c;
                        w[instr_funct12_msb_c:instr_funct12_lsb_c] = funct12_ebreak_c;
                    end else begin // C.JR, C.JALR
                        w[instr_opcode_msb_c:instr_opcode_lsb_c] = opcode_jalr_c;
                        w[instr_rs1_msb_c:instr_rs1_lsb_c]       = rd_5;
                        w[instr_rd_msb_c:instr_rd_lsb_c]         =
                            ci_instr16_i[12] ? reg_ra_c : reg_zero_c;
                    end
                end else begin // C.MV adds to x0, C.ADD to rd
                    w[instr_opcode_msb_c:instr_opcode_lsb_c] = opcode_alu_c;
                    w[instr_funct3_msb_c:instr_funct3_lsb_c] = funct3_subadd_c;
                    w[instr_rd_msb_c:instr_rd_lsb_c]         = rd_5;
                    w[instr_rs1_msb_c:instr_rs1_lsb_c]       = ci_instr16_i[12] ? rd_5 : reg_zero_c;
                    w[instr_rs2_msb_c:instr_rs2_lsb_c]       = rs2_5;
                end
                ill = (funct3 != 3'b100); // Double and quad stack forms
            end
        endcase
    end

    assign result_o = '{instr: w, illegal: ill};

endmodule

// File: design/rvc_decompressor.sv
// RVC expander top level for the fetch stage
// Picks the quadrant result by opcode and registers it, one cycle of latency
module rvc_decompressor
    import rvc_pkg::*;
(
    input  logic     clk_i,
    input  logic     reset_i,
    input  logic     ci_valid_i,
    input  instr16_t ci_instr16_i,
    output logic     out_valid_o,
    output logic     ci_illegal_o,
    output instr32_t ci_instr32_o
);

    rvc_result_t q0_res;
    rvc_result_t q1_res;
    rvc_result_t q2_res;
    rvc_result_t sel_res;

    rvc_quadrant0_decoder u_quadrant0 (
        .ci_instr16_i (ci_instr16_i),
        .result_o     (q0_res)
    );

    rvc_quadrant1_decoder u_quadrant1 (
        .ci_instr16_i (ci_instr16_i),
        .result_o     (q1_res)
    );

    rvc_quadrant2_decoder u_quadrant2 (
        .ci_instr16_i (ci_instr16_i),
        .result_o     (q2_res)
    );

    always_comb begin
        case (ci_instr16_i[ci_opcode_msb_c:ci_opcode_lsb_c])
            2'b00:   sel_res = q0_res;
            2'b01:   sel_res = q1_res;
            default: sel_res = q2_res; // 10, and 11 as well
        endcase
    end

    // ------------------------------------------------------------
    // Fetch-to-decode register
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            out_valid_o  <= 1'b0;
            ci_illegal_o <= 1'b0;
            ci_instr32_o <= '0;
        end else begin
            out_valid_o <= ci_valid_i;
            if (ci_valid_i) begin // Data holds across gaps
                ci_instr32_o <= sel_res.instr;
                ci_illegal_o <= sel_res.illegal;
            end
        end
    end

    // Nothing leaves the stage straight out of reset
    a_valid_after_reset : assert property (
        @(posedge clk_i) reset_i |=> !out_valid_o
    );

    // Every legal expansion lands in the 32-bit opcode space
    a_legal_is_full_size : assert property (
        @(posedge clk_i) disable iff (reset_i)
        (out_valid_o && !ci_illegal_o) |-> (ci_instr32_o[1:0] == 2'b11)
    );

endmodule

// File: testbench/tb_clock_gen.sv
// Clock and reset source for the RVC expander testbench
// 100 time unit period, reset held high over the first five rising edges
module tb_clock_gen (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o;
    end

    initial begin
        reset_o = 1'b1;
        repeat (5) @(posedge clk_o);
        #10 reset_o = 1'b0; // Released off the edge, like the other inputs
    end

endmodule

// File: testbench/tb_rvc_decompressor.sv
// Directed testbench for the RVC expander
// Builds each compressed word and its base expansion from the ISA encodings
module tb_rvc_decompressor
    import rvc_pkg::*;
;

    localparam int clk_period_c    = 100;
    localparam int drive_delay_c   = 10;  // Inputs change this long after the edge
    localparam int reps_c          = 4;   // Random draws per instruction kind
    localparam int illegal_count_c = 17;
    localparam int stream_len_c    = 50;
    localparam int stream_gaps_c   = 15;  // Upper bound, five gaps of up to three
    localparam int total_vectors_c = 26 * reps_c + 1 + illegal_count_c + stream_len_c
                                     + stream_gaps_c + 4;

    typedef enum int {
        k_addi4spn, k_lw, k_sw,
        k_addi, k_jal, k_j, k_li, k_lui, k_addi16sp, k_srli, k_srai, k_andi,
        k_sub, k_xor, k_or, k_and, k_beqz, k_bnez,
        k_slli, k_lwsp, k_swsp, k_jr, k_mv, k_ebreak, k_jalr, k_add
    } kind_t;

    logic     clk;
    logic     reset;
    logic     ci_valid_i;
    instr16_t ci_instr16_i;
    logic     out_valid_o;
    logic     ci_illegal_o;
    instr32_t ci_instr32_o;

    tb_clock_gen u_clock_gen (
        .clk_o   (clk),
        .reset_o (reset)
    );

    rvc_decompressor i_rvc_decompressor (
        .clk_i        (clk),
        .reset_i      (reset),
        .ci_valid_i   (ci_valid_i),
        .ci_instr16_i (ci_instr16_i),
        .out_valid_o  (out_valid_o),
        .ci_illegal_o (ci_illegal_o),
        .ci_instr32_o (ci_instr32_o)
    );

    // ------------------------------------------------------------
    // Base encoding of each compressed form, from semantic fields
    function automatic logic [31:0] tb_expand(input kind_t kind, input logic [4:0] rd,
                                              input logic [4:0] rs1, input logic [4:0] rs2,
                                              input logic [31:0] imm);
        case (kind)
            k_addi4spn, k_addi, k_li, k_addi16sp:
                return {imm[11:0], rs1, funct3_subadd_c, rd, opcode_alui_c};
            k_andi:       return {imm[11:0], rs1, funct3_and_c, rd, opcode_alui_c};
            k_lw, k_lwsp: return {imm[11:0], rs1, funct3_lw_c, rd, opcode_load_c};
            k_sw, k_swsp:
                return {imm[11:5], rs2, rs1, funct3_sw_c, imm[4:0], opcode_store_c};
            k_jal, k_j:
                return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opcode_jal_c};
            k_lui:        return {imm[19:0], rd, opcode_lui_c};
            k_beqz, k_bnez:
                return {imm[12], imm[10:5], rs2, rs1,
                        (kind == k_bnez) ? funct3_bne_c : funct3_beq_c,
                        imm[4:1], imm[11], opcode_branch_c};
            k_srli:  return {funct7_base_c, imm[4:0], rs1, funct3_sr_c, rd, opcode_alui_c};
            k_srai:  return {funct7_alt_c, imm[4:0], rs1, funct3_sr_c, rd, opcode_alui_c};
            k_slli:  return {funct7_base_c, imm[4:0], rs1, funct3_sll_c, rd, opcode_alui_c};
            k_sub:   return {funct7_alt_c, rs2, rs1, funct3_subadd_c, rd, opcode_alu_c};
            k_xor:   return {funct7_base_c, rs2, rs1, funct3_xor_c, rd, opcode_alu_c};
            k_or:    return {funct7_base_c, rs2, rs1, funct3_or_c, rd, opcode_alu_c};
            k_and:   return {funct7_base_c, rs2, rs1, funct3_and_c, rd, opcode_alu_c};
            k_mv, k_add:
                return {funct7_base_c, rs2, rs1, funct3_subadd_c, rd, opcode_alu_c};
            k_jr, k_jalr: return {12'h000, rs1, 3'b000, rd, opcode_jalr_c};
            default: return {funct12_ebreak_c, reg_zero_c, 3'b000, reg_zero_c, opcode_system_c};
        endcase
    endfunction

    // Random legal compressed word of one kind, with its expected expansion
    task automatic build_legal(input kind_t kind, output logic [15:0] c16,
                               output logic [31:0] exp32);
        logic [31:0] r;
        logic [31:0] imm;
        logic [2:0]  rp;
        logic [2:0]  rq;
        logic [4:0]  r5;
        logic [4:0]  s5;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        r   = $urandom;
        rp  = r[18:16];
        rq  = r[21:19];
        r5  = 5'($urandom_range(1, 31)); // Nonzero full register
        s5  = 5'($urandom_range(1, 31));
        rd  = 5'd8 + rp;                 // x8 - x15 by default
        rs1 = rd;
        rs2 = 5'd8 + rq;
        imm = '0;
        c16 = '0;
        case (kind)
            k_addi4spn: begin
                imm = (r[7:0] == 8'd0) ? 32'd4 : {22'd0, r[7:0], 2'b00};
                rs1 = reg_sp_c;
                c16 = {3'b000, imm[5:4], imm[9:6], imm[2], imm[3], rp, 2'b00};
            end
            k_lw, k_sw: begin
                imm = {25'd0, r[4:0], 2'b00};
                rd  = 5'd8 + rq;
                c16 = {(kind == k_lw) ? 3'b010 : 3'b110, imm[5:3], rp, imm[2], imm[6],
                       rq, 2'b00};
            end
            k_addi, k_li: begin
                imm = {{26{r[5]}}, r[5:0]};
                rd  = r5;
                rs1 = (kind == k_li) ? reg_zero_c : r5;
                c16 = {(kind == k_li) ? 3'b010 : 3'b000, imm[5], r5, imm[4:0], 2'b01};
            end
            k_jal, k_j: begin
                imm = {{20{r[10]}}, r[10:0], 1'b0};
                rd  = (kind == k_jal) ? reg_ra_c : reg_zero_c;
                c16 = {(kind == k_jal) ? 3'b001 : 3'b101, imm[11], imm[4], imm[9:8],
                       imm[10], imm[6], imm[7], imm[3:1], imm[5], 2'b01};
            end
            k_lui: begin
                rd  = (r5 == reg_sp_c) ? 5'd3 : r5; // rd of x2 would be C.ADDI16SP
                imm = (r[5:0] == 6'd0) ? 32'd1 : {{26{r[5]}}, r[5:0]};
                c16 = {3'b011, imm[5], rd, imm[4:0], 2'b01};
            end
            k_addi16sp: begin
                imm = (r[5:0] == 6'd0) ? 32'd16 : {{22{r[5]}}, r[5:0], 4'b0000};
                rd  = reg_sp_c;
                rs1 = reg_sp_c;
                c16 = {3'b011, imm[9], reg_sp_c, imm[4], imm[6], imm[8:7], imm[5], 2'b01};
            end
            k_srli, k_srai: begin
                imm = {27'd0, r[4:0]};
                c16 = {3'b100, 1'b0, (kind == k_srai) ? 2'b01 : 2'b00, rp, imm[4:0], 2'b01};
            end
            k_andi: begin
                imm = {{26{r[5]}}, r[5:0]};
                c16 = {3'b100, imm[5], 2'b10, rp, imm[4:0], 2'b01};
            end
            k_sub, k_xor, k_or, k_and:
                c16 = {3'b100, 1'b0, 2'b11, rp, 2'(kind - k_sub), rq, 2'b01};
            k_beqz, k_bnez: begin
                imm = {{23{r[7]}}, r[7:0], 1'b0};
                rs2 = reg_zero_c;
                c16 = {(kind == k_bnez) ? 3'b111 : 3'b110, imm[8], imm[4:3], rp,
                       imm[7:6], imm[2:1], imm[5], 2'b01};
            end
            k_slli: begin
                imm = {27'd0, r[4:0]};
                rd  = r5;
                rs1 = r5;
                c16 = {3'b000, 1'b0, r5, imm[4:0], 2'b10};
            end
            k_lwsp, k_swsp: begin
                imm = {24'd0, r[5:0], 2'b00};
                rs1 = reg_sp_c;
                rd  = r5;
                rs2 = r5;
                if (kind == k_lwsp)
                    c16 = {3'b010, imm[5], r5, imm[4:2], imm[7:6], 2'b10};
                else
                    c16 = {3'b110, imm[5:2], imm[7:6], r5, 2'b10};
            end
            k_jr, k_jalr: begin
                rs1 = r5;
                rd  = (kind == k_jalr) ? reg_ra_c : reg_zero_c;
                c16 = {3'b100, kind == k_jalr, r5, 5'd0, 2'b10};
            end
            k_mv, k_add: begin
                rd  = r5;
                rs2 = s5;
                rs1 = (kind == k_add) ? r5 : reg_zero_c;
                c16 = {3'b100, kind == k_add, r5, s5, 2'b10};
            end
            default: c16 = 16'h9002; // C.EBREAK has one encoding
        endcase
        exp32 = tb_expand(kind, rd, rs1, rs2, imm);
    endtask

    // ------------------------------------------------------------
    task automatic stop_on_error();
        $display("TEST FAIL");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_value(input string test, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("CHECK FAILED %s expected %h actual %h", test, expected, actual);
            stop_on_error();
        end
    endtask

    // One strobe, then the result is due exactly one cycle later
    task automatic send_one(input string name, input logic [15:0] c16,
                            input logic [31:0] exp32, input logic exp_ill,
                            input logic check_word);
        @(posedge clk);
        #drive_delay_c;
        ci_valid_i   = 1'b1;
        ci_instr16_i = c16;
        @(posedge clk);
        #drive_delay_c;
        ci_valid_i = 1'b0;
        assert (out_valid_o === 1'b1) else begin
            $display("ERROR: %s saw no out_valid_o one cycle after the strobe", name);
            stop_on_error();
        end
        check_value({name, " illegal"}, exp_ill, ci_illegal_o);
        if (check_word)
            check_value(name, exp32, ci_instr32_o);
    endtask

    task automatic run_kinds(input string name, input int first, input int last);
        logic [15:0] c16;
        logic [31:0] exp32;
        kind_t       kind;
        int          k;
        int          n;
        for (k = first; k <= last; k++) begin
            kind = kind_t'(k);
            for (n = 0; n < reps_c; n++) begin
                build_legal(kind, c16, exp32);
                send_one({name, " ", kind.name()}, c16, exp32, 1'b0, 1'b1);
            end
        end
    endtask

    // ------------------------------------------------------------
    task automatic test_reset();
        check_value("test_reset valid", 32'd0, out_valid_o);
        check_value("test_reset illegal", 32'd0, ci_illegal_o);
        check_value("test_reset word", 32'd0, ci_instr32_o);
        @(posedge clk);
        #drive_delay_c;
        check_value("test_reset idle valid", 32'd0, out_valid_o); // No strobe yet
    endtask

    task automatic test_quadrant0();
        run_kinds("test_quadrant0", k_addi4spn, k_sw);
    endtask

    task automatic test_quadrant1();
        send_one("test_quadrant1 c_nop", 16'h0001, tb_expand(k_addi, 5'd0, 5'd0, 5'd0, 32'd0),
                 1'b0, 1'b1);
        run_kinds("test_quadrant1", k_addi, k_bnez);
    endtask

    task automatic test_quadrant2();
        run_kinds("test_quadrant2", k_slli, k_add);
    endtask

    task automatic test_illegal();
        logic [31:0] r;
        int          f;
        r = $urandom;
        send_one("test_illegal all_zero", 16'h0000, '0, 1'b1, 1'b0);
        send_one("test_illegal addi4spn_zero", {3'b000, 8'h00, r[2:0], 2'b00}, '0, 1'b1, 1'b0);
        send_one("test_illegal lui_zero", {3'b011, 1'b0, 5'd5, 5'd0, 2'b01}, '0, 1'b1, 1'b0);
        send_one("test_illegal addi16sp_zero", {3'b011, 1'b0, reg_sp_c, 5'd0, 2'b01},
                 '0, 1'b1, 1'b0);
        send_one("test_illegal srli_bit12", {3'b100, 1'b1, 2'b00, r[2:0], r[9:5], 2'b01},
                 '0, 1'b1, 1'b0);
        send_one("test_illegal srai_bit12", {3'b100, 1'b1, 2'b01, r[2:0], r[9:5], 2'b01},
                 '0, 1'b1, 1'b0);
        send_one("test_illegal alu_bit12", {3'b100, 1'b1, 2'b11, r[2:0], r[9:5], 2'b01},
                 '0, 1'b1, 1'b0);
        send_one("test_illegal slli_bit12", {3'b000, 1'b1, r[14:10], r[9:5], 2'b10},
                 '0, 1'b1, 1'b0);
        // Reserved and float slots of quadrants 0 and 2
        for (f = 0; f < 8; f++) begin
            r = $urandom;
            if (f != 0 && f != 2 && f != 6)
                send_one("test_illegal q0_funct3", {f[2:0], r[10:0], 2'b00}, '0, 1'b1, 1'b0);
            if (f[0])
                send_one("test_illegal q2_funct3", {f[2:0], r[10:0], 2'b10}, '0, 1'b1, 1'b0);
        end
    endtask

    // Back to back strobes in runs of ten, short gaps between runs
    task automatic test_stream();
        logic [15:0] c16;
        logic [31:0] exp32;
        logic [31:0] last_exp;
        logic        last_valid;
        int          sent;
        int          gap;
        sent       = 0;
        gap        = 0;
        last_exp   = '0;
        last_valid = 1'b0;
        while (sent < stream_len_c || last_valid) begin
            @(posedge clk);
            #drive_delay_c;
            if (sent > 0) begin // Outputs now show the previous cycle's input
                check_value("test_stream valid", last_valid, out_valid_o);
                check_value("test_stream word", last_exp, ci_instr32_o);
                check_value("test_stream illegal", 32'd0, ci_illegal_o);
            end
            if (gap > 0 || sent == stream_len_c) begin
                ci_valid_i = 1'b0;
                last_valid = 1'b0;
                if (gap > 0)
                    gap--;
            end else begin
                build_legal(kind_t'($urandom_range(0, 25)), c16, exp32);
                ci_valid_i   = 1'b1;
                ci_instr16_i = c16;
                last_exp     = exp32;
                last_valid   = 1'b1;
                sent++;
                if (sent % 10 == 0)
                    gap = 1 + $urandom_range(2);
            end
        end
        @(posedge clk);
        #drive_delay_c;
        check_value("test_stream final valid", 32'd0, out_valid_o);
    endtask

    // ------------------------------------------------------------
    initial begin
        ci_valid_i   = 1'b0;
        ci_instr16_i = '0;
        void'($urandom(25)); // Fixed seed for repeatable runs
        @(negedge reset);
        test_reset();
        test_quadrant0();
        test_quadrant1();
        test_quadrant2();
        test_illegal();
        test_stream();
        $display("TEST PASS");
        $finish;
    end

    // Watchdog sized from the vector count
    initial begin
        #((total_vectors_c + 20) * clk_period_c * 2);
        $display("ERROR: watchdog expired before the tests completed");
        $display("TEST FAIL");
        $fatal(1, "Timeout");
    end

endmodule

// File: rvc_decompressor.f
design/rvc_pkg.sv
design/rvc_quadrant0_decoder.sv
design/rvc_quadrant1_decoder.sv
design/rvc_quadrant2_decoder.sv
design/rvc_decompressor.sv
testbench/tb_clock_gen.sv
testbench/tb_rvc_decompressor.sv
